// File: hw/sdram_pkg.sv
// SDRAM controller definitions
`default_nettype none

package sdram_pkg;

    // --------------------
    // Device geometry
    // --------------------
    localparam int DATA_W = 16;
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int BANK_W = 2;
    localparam int ADDR_W = ROW_W + BANK_W + COL_W;

    // Host address layout, row above bank above column
    localparam int COL_LSB  = 0;
    localparam int BANK_LSB = COL_LSB + COL_W;
    localparam int ROW_LSB  = BANK_LSB + BANK_W;

    // --------------------
    // Timing in clk cycles
    // --------------------
    localparam int T_RST_DLY      = 200;
    localparam int T_RP           = 3;
    localparam int T_RFC          = 8;
    localparam int T_MRD          = 2;
    localparam int T_RCD          = 3;
    localparam int T_REF_INTERVAL = 300;
    localparam int CAS_LATENCY    = 2;

    localparam int TIMER_W   = $clog2(T_RST_DLY + 1);
    localparam int REF_TMR_W = $clog2(T_REF_INTERVAL + 1);
    localparam int REF_CNT_W = 4;

    typedef logic [TIMER_W-1:0]   timer_t;
    typedef logic [REF_TMR_W-1:0] ref_tmr_t;
    typedef logic [REF_CNT_W-1:0] ref_cnt_t;

    // --------------------
    // Mode register
    // --------------------
    localparam logic [2:0] BURST_LEN_1     = 3'b000;
    localparam logic       BURST_SEQ       = 1'b0;
    localparam logic [2:0] CAS_FIELD       = 3'(CAS_LATENCY);
    localparam logic [1:0] OP_STANDARD     = 2'b00;
    localparam logic       WR_BURST_SINGLE = 1'b1;

    // A[12:10] reserved, then write burst mode, op mode, CL, burst type, length
    localparam logic [ROW_W-1:0] MODE_WORD = {
        3'b000, WR_BURST_SINGLE, OP_STANDARD, CAS_FIELD, BURST_SEQ, BURST_LEN_1
    };

    // Sequencer states
    typedef enum logic [3:0] {
        RESET,
        RST_DLY,
        WAIT_START,
        INIT_NOP,
        INIT_PRECHG,
        INIT_REF1,
        INIT_REF2,
        LMR,
        IDLE,
        REFRESH,
        ACTIVE,
        READ,
        WRITE,
        PRECHG
    } seq_state_t;

    // One host access
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              wr;
        logic [DATA_W-1:0] wdata;
    } host_cmd_t;

    // SDRAM control pins, active low where prefixed with n
    typedef struct packed {
        logic              cke;
        logic              ncs;
        logic              nras;
        logic              ncas;
        logic              nwe;
        logic              dqml;
        logic              dqmh;
        logic [BANK_W-1:0] ba;
        logic [ROW_W-1:0]  a;
    } sdram_pins_t;

endpackage

`default_nettype wire

// File: hw/sdram_seq.sv
// SDRAM command sequencer
`default_nettype none

module sdram_seq (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire logic                  cmd_req,
    input  wire sdram_pkg::host_cmd_t  cmd,
    input  wire logic                  refresh_pending,
    output sdram_pkg::seq_state_t      state,
    output logic                       timer_busy,
    output sdram_pkg::host_cmd_t       cur_cmd,
    output logic                       cmd_accepted,
    output logic                       cmd_done_wr,
    output logic                       refresh_issue,
    output logic                       init_done,
    output logic                       read_issue
);

    sdram_pkg::seq_state_t  next_state;
    sdram_pkg::timer_t      timer;
    sdram_pkg::timer_t      timer_load;
    logic                   timer_done;

    // Last cycle of a timed state
    assign timer_done = (timer == sdram_pkg::timer_t'(1));

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            sdram_pkg::RESET: begin
                next_state = sdram_pkg::RST_DLY;
            end
            sdram_pkg::RST_DLY: begin
                if (timer_done) next_state = sdram_pkg::WAIT_START;
            end
            sdram_pkg::WAIT_START: begin
                if (start) next_state = sdram_pkg::INIT_NOP;
            end
            sdram_pkg::INIT_NOP: begin
                next_state = sdram_pkg::INIT_PRECHG;
            end
            sdram_pkg::INIT_PRECHG: begin
                if (timer_done) next_state = sdram_pkg::INIT_REF1;
            end
            sdram_pkg::INIT_REF1: begin
                if (timer_done) next_state = sdram_pkg::INIT_REF2;
            end
            sdram_pkg::INIT_REF2: begin
                if (timer_done) next_state = sdram_pkg::LMR;
            end
            sdram_pkg::IDLE: begin
                // Host access wins over a pending refresh
                if (cmd_req) begin
                    next_state = sdram_pkg::ACTIVE;
                end else if (refresh_pending) begin
                    next_state = sdram_pkg::REFRESH;
                end
            end
            sdram_pkg::ACTIVE: begin
                if (timer_done) begin
                    next_state = cur_cmd.wr ? sdram_pkg::WRITE : sdram_pkg::READ;
                end
            end
            sdram_pkg::READ, sdram_pkg::WRITE: begin
                next_state = sdram_pkg::PRECHG;
            end
            sdram_pkg::LMR, sdram_pkg::REFRESH, sdram_pkg::PRECHG: begin
                if (timer_done) next_state = sdram_pkg::IDLE;
            end
            default: begin
                next_state = sdram_pkg::RESET;
            end
        endcase
    end

    // Wait time of the state being entered
    always_comb begin
        case (next_state)
            sdram_pkg::RST_DLY: begin
                timer_load = sdram_pkg::timer_t'(sdram_pkg::T_RST_DLY);
            end
            sdram_pkg::INIT_PRECHG, sdram_pkg::PRECHG: begin
                timer_load = sdram_pkg::timer_t'(sdram_pkg::T_RP);
            end
            sdram_pkg::INIT_REF1, sdram_pkg::INIT_REF2, sdram_pkg::REFRESH: begin
                timer_load = sdram_pkg::timer_t'(sdram_pkg::T_RFC);
            end
            sdram_pkg::LMR: begin
                timer_load = sdram_pkg::timer_t'(sdram_pkg::T_MRD);
            end
            sdram_pkg::ACTIVE: begin
                timer_load = sdram_pkg::timer_t'(sdram_pkg::T_RCD);
            end
            default: begin
                timer_load = '0;
            end
        endcase
    end

    // --------------------
    // State and timer
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= sdram_pkg::RESET;
            timer      <= '0;
            timer_busy <= 1'b0;
        end else begin
            state      <= next_state;
            // Low only in the first cycle of a state, where the command goes out
            timer_busy <= (next_state == state);
            if (next_state != state) begin
                timer <= timer_load;
            end else if (timer != '0) begin
                timer <= timer - 1'b1;
            end
        end
    end

    // Address and data stay fixed from ACTIVE to the end of the access
    always_ff @(posedge clk) begin
        if (state == sdram_pkg::IDLE && next_state == sdram_pkg::ACTIVE) begin
            cur_cmd <= cmd;
        end
    end

    // Handshake and side pulses
    assign cmd_accepted  = (state == sdram_pkg::READ) || (state == sdram_pkg::WRITE);
    assign cmd_done_wr   = (state == sdram_pkg::WRITE);
    assign read_issue    = (state == sdram_pkg::READ);
    assign refresh_issue = (state == sdram_pkg::REFRESH) && !timer_busy;
    assign init_done     = (state == sdram_pkg::INIT_REF2) && (next_state != state);

endmodule

`default_nettype wire

// File: hw/refresh_sched.sv
// Auto-refresh scheduler
`default_nettype none

module refresh_sched (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  init_done,
    input  wire logic  refresh_issue,
    output logic       refresh_pending
);

    sdram_pkg::ref_tmr_t  interval_cnt;
    sdram_pkg::ref_cnt_t  pending_cnt;
    logic                 interval_wrap;

    // One refresh owed every T_REF_INTERVAL + 1 cycles
    assign interval_wrap = (interval_cnt == sdram_pkg::ref_tmr_t'(sdram_pkg::T_REF_INTERVAL));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interval_cnt <= '0;
        end else if (init_done || interval_wrap) begin
            interval_cnt <= '0;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    // Saturating count of owed refreshes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending_cnt <= '0;
        end else if (init_done) begin
            pending_cnt <= '0;
        end else if (interval_wrap && !refresh_issue) begin
            if (pending_cnt != '1) pending_cnt <= pending_cnt + 1'b1;
        end else if (refresh_issue && !interval_wrap) begin
            if (pending_cnt != '0) pending_cnt <= pending_cnt - 1'b1;
        end
    end

    assign refresh_pending = (pending_cnt != '0);

endmodule

`default_nettype wire

// File: hw/cmd_encode.sv
// SDRAM command encoder
`default_nettype none

module cmd_encode (
    input  wire sdram_pkg::seq_state_t    state,
    input  wire logic                     timer_busy,
    input  wire sdram_pkg::host_cmd_t     cur_cmd,
    output sdram_pkg::sdram_pins_t        pins,
    output logic [sdram_pkg::DATA_W-1:0]  dq_out,
    output logic                          dq_oe
);

    always_comb begin
        // Inhibit unless a state below says otherwise
        pins.cke  = 1'b1;
        pins.ncs  = 1'b1;
        pins.nras = 1'b1;
        pins.ncas = 1'b1;
        pins.nwe  = 1'b1;
        pins.dqml = 1'b0;
        pins.dqmh = 1'b0;
        pins.ba   = '0;
        pins.a    = '0;

        case (state)
            sdram_pkg::RESET, sdram_pkg::RST_DLY,
            sdram_pkg::WAIT_START, sdram_pkg::IDLE: begin
                pins.ncs = 1'b1;
            end
            default: begin
                pins.ncs = 1'b0;
                // Waiting out a command, NOP
                if (!timer_busy) begin
                    case (state)
                        sdram_pkg::INIT_PRECHG, sdram_pkg::PRECHG: begin
                            pins.nras  = 1'b0;
                            pins.nwe   = 1'b0;
                            // All banks
                            pins.a[10] = 1'b1;
                        end
                        sdram_pkg::INIT_REF1, sdram_pkg::INIT_REF2,
                        sdram_pkg::REFRESH: begin
                            pins.nras = 1'b0;
                            pins.ncas = 1'b0;
                        end
                        sdram_pkg::LMR: begin
                            pins.nras = 1'b0;
                            pins.ncas = 1'b0;
                            pins.nwe  = 1'b0;
                            pins.a    = sdram_pkg::MODE_WORD;
                        end
                        sdram_pkg::ACTIVE: begin
                            pins.nras = 1'b0;
                            pins.ba   = cur_cmd.addr[sdram_pkg::BANK_LSB +: sdram_pkg::BANK_W];
                            pins.a    = cur_cmd.addr[sdram_pkg::ROW_LSB +: sdram_pkg::ROW_W];
                        end
                        sdram_pkg::READ, sdram_pkg::WRITE: begin
                            pins.ncas = 1'b0;
                            pins.nwe  = (state != sdram_pkg::WRITE);
                            pins.ba   = cur_cmd.addr[sdram_pkg::BANK_LSB +: sdram_pkg::BANK_W];
                            // A10 stays low, no auto-precharge
                            pins.a[sdram_pkg::COL_W-1:0] =
                                cur_cmd.addr[sdram_pkg::COL_LSB +: sdram_pkg::COL_W];
                        end
                        default: begin
                            pins.nras = 1'b1;
                        end
                    endcase
                end
            end
        endcase
    end

    // Write data on the bus only with the WRITE command
    assign dq_out = cur_cmd.wdata;
    assign dq_oe  = (state == sdram_pkg::WRITE);

endmodule

`default_nettype wire

// File: hw/read_capture.sv
// Read data capture
`default_nettype none

module read_capture (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           read_issue,
    input  wire logic [sdram_pkg::DATA_W-1:0]   dq_in,
    output logic                                cmd_done_rd,
    output logic [sdram_pkg::DATA_W-1:0]        rd_data
);

    // One stage per cycle of CAS latency
    logic [sdram_pkg::CAS_LATENCY-1:0]  valid_pipe;
    logic [sdram_pkg::DATA_W-1:0]       data_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[sdram_pkg::CAS_LATENCY-2:0], read_issue};
        end
    end

    assign cmd_done_rd = valid_pipe[sdram_pkg::CAS_LATENCY-1];

    always_ff @(posedge clk) begin
        if (cmd_done_rd) begin
            data_q <= dq_in;
        end
    end

    // Bus data in the done cycle, held copy afterwards
    assign rd_data = cmd_done_rd ? dq_in : data_q;

endmodule

`default_nettype wire

// File: hw/sdram_ctrl.sv
// SDRAM controller top level
`default_nettype none

module sdram_ctrl (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         start,
    input  wire logic                         cmd_req,
    input  wire sdram_pkg::host_cmd_t         cmd,
    output logic                              cmd_accepted,
    output logic                              cmd_done,
    output logic [sdram_pkg::DATA_W-1:0]      rd_data,
    output logic                              sdram_clk,
    output sdram_pkg::sdram_pins_t            pins,
    inout  wire  [sdram_pkg::DATA_W-1:0]      dq
);

    sdram_pkg::seq_state_t          state;
    sdram_pkg::host_cmd_t           cur_cmd;
    logic                           timer_busy;
    logic                           refresh_pending;
    logic                           refresh_issue;
    logic                           init_done;
    logic                           read_issue;
    logic                           cmd_done_wr;
    logic                           cmd_done_rd;
    logic                           dq_oe;
    logic [sdram_pkg::DATA_W-1:0]   dq_out;

    // Device runs on the controller clock
    assign sdram_clk = clk;

    assign dq       = dq_oe ? dq_out : 'z;
    assign cmd_done = cmd_done_wr | cmd_done_rd;

    sdram_seq u_seq (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .cmd_req         (cmd_req),
        .cmd             (cmd),
        .refresh_pending (refresh_pending),
        .state           (state),
        .timer_busy      (timer_busy),
        .cur_cmd         (cur_cmd),
        .cmd_accepted    (cmd_accepted),
        .cmd_done_wr     (cmd_done_wr),
        .refresh_issue   (refresh_issue),
        .init_done       (init_done),
        .read_issue      (read_issue)
    );

    refresh_sched u_refresh (
        .clk             (clk),
        .reset           (reset),
        .init_done       (init_done),
        .refresh_issue   (refresh_issue),
        .refresh_pending (refresh_pending)
    );

    cmd_encode u_encode (
        .state      (state),
        .timer_busy (timer_busy),
        .cur_cmd    (cur_cmd),
        .pins       (pins),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe)
    );

    read_capture u_capture (
        .clk         (clk),
        .reset       (reset),
        .read_issue  (read_issue),
        .dq_in       (dq),
        .cmd_done_rd (cmd_done_rd),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: verification/sdram_model.sv
// Behavioral SDRAM device
`default_nettype none

module sdram_model (
    input  wire logic                        clk,
    input  wire sdram_pkg::sdram_pins_t      pins,
    inout  wire [sdram_pkg::DATA_W-1:0]      dq,
    output int                               error_count,
    output int                               refresh_count,
    output int                               init_count
);

    localparam int CL = sdram_pkg::CAS_LATENCY;

    // Command codes on {nras, ncas, nwe}
    localparam logic [2:0] OP_LMR = 3'b000;
    localparam logic [2:0] OP_REF = 3'b001;
    localparam logic [2:0] OP_PRE = 3'b010;
    localparam logic [2:0] OP_ACT = 3'b011;
    localparam logic [2:0] OP_WR  = 3'b100;
    localparam logic [2:0] OP_RD  = 3'b101;
    localparam logic [2:0] OP_NOP = 3'b111;

    // Single write burst, standard op, CL, sequential, burst length 1
    localparam logic [sdram_pkg::ROW_W-1:0] EXP_MODE = {
        3'b000, 1'b1, 2'b00, 3'(CL), 1'b0, 3'b000
    };

    // Sparse storage, key is {row, bank, col}
    logic [sdram_pkg::ADDR_W-1:0]  keys [$];
    logic [sdram_pkg::DATA_W-1:0]  words [$];
    logic [sdram_pkg::ROW_W-1:0]   open_row [2**sdram_pkg::BANK_W];
    logic [CL-1:0]                 rd_valid = '0;
    logic [sdram_pkg::DATA_W-1:0]  rd_word [CL];
    int errs = 0;
    int refs = 0;
    int inits = 0;
    int since_ref = 1000;
    int since_pre = 1000;

    assign error_count   = errs;
    assign refresh_count = refs;
    assign init_count    = inits;

    // Read data shows up CL cycles after the READ edge
    assign dq = rd_valid[CL-1] ? rd_word[CL-1] : 'z;

    function automatic int find_key(input logic [sdram_pkg::ADDR_W-1:0] key);
        int idx;
        idx = -1;
        for (int i = 0; i < keys.size(); i++) begin
            if (keys[i] == key) idx = i;
        end
        return idx;
    endfunction

    always @(posedge clk) begin : decode
        logic [2:0]                    op;
        logic                          is_cmd;
        logic                          init_ok;
        logic [sdram_pkg::ADDR_W-1:0]  key;
        int                            idx;

        op      = {pins.nras, pins.ncas, pins.nwe};
        is_cmd  = (pins.cke === 1'b1) && (pins.ncs === 1'b0) && (op != OP_NOP);
        key     = {open_row[pins.ba], pins.ba, pins.a[sdram_pkg::COL_W-1:0]};
        since_ref = since_ref + 1;
        since_pre = since_pre + 1;

        rd_valid <= {rd_valid[CL-2:0], is_cmd && (op == OP_RD)};
        for (int i = 1; i < CL; i++) rd_word[i] <= rd_word[i-1];

        if (is_cmd) begin
            if (since_ref < sdram_pkg::T_RFC) begin
                $display("ERROR at %0t: command %b %0d cycles after refresh", $time, op, since_ref);
                errs = errs + 1;
            end
            if (since_pre < sdram_pkg::T_RP) begin
                $display("ERROR at %0t: command %b %0d cycles after precharge", $time, op,
                         since_pre);
                errs = errs + 1;
            end

            // First four commands form the power-up sequence
            if (inits < 4) begin
                case (inits)
                    0:       init_ok = (op == OP_PRE) && pins.a[10];
                    1, 2:    init_ok = (op == OP_REF);
                    default: init_ok = (op == OP_LMR) && (pins.a == EXP_MODE);
                endcase
                if (!init_ok) begin
                    $display("ERROR at %0t: init command %0d is %b with a=%h", $time, inits,
                             op, pins.a);
                    errs = errs + 1;
                end
                inits = inits + 1;
            end

            case (op)
                OP_REF: begin
                    refs = refs + 1;
                    since_ref = 0;
                end
                OP_PRE: since_pre = 0;
                OP_ACT: open_row[pins.ba] = pins.a;
                OP_WR: begin
                    idx = find_key(key);
                    if (idx < 0) begin
                        keys.push_back(key);
                        words.push_back(dq);
                    end else begin
                        words[idx] = dq;
                    end
                end
                OP_RD: begin
                    idx = find_key(key);
                    if (idx < 0) rd_word[0] <= key[15:0] ^ {8'h00, key[23:16]};
                    else rd_word[0] <= words[idx];
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_sdram_ctrl.sv
// SDRAM controller testbench
`default_nettype none

module tb_sdram_ctrl;

    localparam int CLK_PERIOD = 40;
    // Long idle stretch for the refresh rate check
    localparam int IDLE_GAP = 3 * (sdram_pkg::T_REF_INTERVAL + 1);

    logic                           clk;
    logic                           reset;
    logic                           start;
    logic                           cmd_req;
    sdram_pkg::host_cmd_t           cmd;
    logic                           cmd_accepted;
    logic                           cmd_done;
    logic [sdram_pkg::DATA_W-1:0]   rd_data;
    logic                           sdram_clk;
    sdram_pkg::sdram_pins_t         pins;
    wire  [sdram_pkg::DATA_W-1:0]   dq;
    int                             model_errors;
    int                             refresh_count;
    int                             init_count;

    // Test table from the data file
    logic [sdram_pkg::ADDR_W-1:0]   test_addr [$];
    logic [sdram_pkg::DATA_W-1:0]   test_data [$];
    logic                           test_wr [$];

    logic [31:0] rng_state = 32'h95ab;
    logic        loaded = 1'b0;
    int          requests = 0;
    int          acc_total = 0;
    int          done_total = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    sdram_ctrl dut0 (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cmd_req      (cmd_req),
        .cmd          (cmd),
        .cmd_accepted (cmd_accepted),
        .cmd_done     (cmd_done),
        .rd_data      (rd_data),
        .sdram_clk    (sdram_clk),
        .pins         (pins),
        .dq           (dq)
    );

    sdram_model mem0 (
        .clk           (sdram_clk),
        .pins          (pins),
        .dq            (dq),
        .error_count   (model_errors),
        .refresh_count (refresh_count),
        .init_count    (init_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Handshake pulse counters over the whole run
    always @(posedge clk) begin
        if (cmd_accepted === 1'b1) acc_total <= acc_total + 1;
        if (cmd_done === 1'b1) done_total <= done_total + 1;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void note_result(input bit ok);
        if (ok) pass_count = pass_count + 1;
        else fail_count = fail_count + 1;
    endfunction

    task automatic load_tests();
        int                             fd;
        int                             rc;
        int                             ch;
        logic [8*8-1:0]                 tok;
        logic [sdram_pkg::ADDR_W-1:0]   a;
        logic [sdram_pkg::DATA_W-1:0]   d;
        fd = $fopen("verification/sdram_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/sdram_tests.txt, no accesses run");
            fail_count = fail_count + 1;
        end else begin
            while (!$feof(fd)) begin
                rc = $fscanf(fd, "%s", tok);
                if (rc == 1 && tok == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) ch = $fgetc(fd);
                end else if (rc == 1) begin
                    rc = $fscanf(fd, "%h %h", a, d);
                    if (rc != 2 || (tok != "W" && tok != "R")) begin
                        $display("Malformed line in test file near token %0s", tok);
                        fail_count = fail_count + 1;
                    end else begin
                        test_addr.push_back(a);
                        test_data.push_back(d);
                        test_wr.push_back(tok == "W");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_access(input int idx);
        logic [sdram_pkg::ADDR_W-1:0]   addr;
        logic [sdram_pkg::DATA_W-1:0]   data;
        logic [sdram_pkg::DATA_W-1:0]   got;
        logic [sdram_pkg::ROW_W-1:0]    act_row;
        logic [sdram_pkg::BANK_W-1:0]   act_bank;
        logic [sdram_pkg::ROW_W-1:0]    cas_a;
        logic [sdram_pkg::BANK_W-1:0]   cas_bank;
        logic [sdram_pkg::ROW_W-1:0]    exp_row;
        logic [sdram_pkg::BANK_W-1:0]   exp_bank;
        logic [sdram_pkg::ROW_W-1:0]    exp_cas_a;
        logic                           is_wr;
        bit                             ok;
        int                             cyc;
        int                             acc_cyc;
        int                             done_cyc;
        addr     = test_addr[idx];
        data     = test_data[idx];
        is_wr    = test_wr[idx];
        ok       = 1'b1;
        cyc      = 0;
        acc_cyc  = -1;
        done_cyc = -1;
        act_row  = 'x;
        act_bank = 'x;
        cas_a    = 'x;
        cas_bank = 'x;

        // Row above bank above column, A10 low with the column
        exp_row   = addr[sdram_pkg::ADDR_W-1 -: sdram_pkg::ROW_W];
        exp_bank  = addr[sdram_pkg::COL_W +: sdram_pkg::BANK_W];
        exp_cas_a = '0;
        exp_cas_a[sdram_pkg::COL_W-1:0] = addr[sdram_pkg::COL_W-1:0];

        @(posedge clk);
        cmd_req     <= 1'b1;
        cmd.addr    <= addr;
        cmd.wr      <= is_wr;
        cmd.wdata   <= is_wr ? data : '0;
        requests = requests + 1;

        while (done_cyc < 0) begin
            @(posedge clk);
            cyc = cyc + 1;
            // ACTIVE command on the pins
            if (pins.ncs === 1'b0 && {pins.nras, pins.ncas, pins.nwe} === 3'b011) begin
                act_row  = pins.a;
                act_bank = pins.ba;
            end
            if (cmd_accepted) begin
                if (acc_cyc < 0) begin
                    acc_cyc  = cyc;
                    cas_a    = pins.a;
                    cas_bank = pins.ba;
                end
                cmd_req <= 1'b0;
            end
            if (cmd_done) begin
                done_cyc = cyc;
                got = rd_data;
            end
        end

        if (acc_cyc < 0 || (is_wr && done_cyc != acc_cyc)) begin
            $display("ERROR at %0t: write done at cycle %0d, accepted at %0d", $time,
                     done_cyc, acc_cyc);
            ok = 1'b0;
        end
        if (!is_wr && done_cyc - acc_cyc != sdram_pkg::CAS_LATENCY) begin
            $display("ERROR at %0t: read done %0d cycles after accept, expected %0d", $time,
                     done_cyc - acc_cyc, sdram_pkg::CAS_LATENCY);
            ok = 1'b0;
        end
        if (!is_wr && got !== data) begin
            $display("ERROR at %0t: read %h returned %h, expected %h", $time, addr, got, data);
            ok = 1'b0;
        end
        if (act_row !== exp_row || act_bank !== exp_bank || cas_bank !== exp_bank
            || cas_a !== exp_cas_a) begin
            $display("ERROR at %0t: address %h sent as row %h bank %h, then bank %h a %h",
                     $time, addr, act_row, act_bank, cas_bank, cas_a);
            ok = 1'b0;
        end

        @(posedge clk);
        if (acc_total != requests) begin
            $display("ERROR at %0t: %0d accepts for %0d requests", $time, acc_total, requests);
            ok = 1'b0;
        end
        $display("test %0d: %s %h %h %s", idx, is_wr ? "W" : "R", addr, data,
                 ok ? "ok" : "FAIL");
        note_result(ok);

        rng_state = next_rand(rng_state);
        repeat (rng_state[2:0]) @(posedge clk);
    endtask

    task automatic check_refresh_rate();
        int r0;
        int expected;
        int diff;
        @(negedge clk);
        r0 = refresh_count;
        repeat (IDLE_GAP) @(negedge clk);
        expected = IDLE_GAP / (sdram_pkg::T_REF_INTERVAL + 1);
        diff = (refresh_count - r0) - expected;
        if (diff > 1 || diff < -1) begin
            $display("ERROR at %0t: %0d refreshes in %0d idle cycles, expected %0d", $time,
                     refresh_count - r0, IDLE_GAP, expected);
        end
        $display("test refresh: %0d in %0d cycles %s", refresh_count - r0, IDLE_GAP,
                 (diff > 1 || diff < -1) ? "FAIL" : "ok");
        note_result(diff <= 1 && diff >= -1);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main
        reset   = 1'b1;
        start   = 1'b0;
        cmd_req = 1'b0;
        cmd     = '0;
        load_tests();
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        start <= 1'b1;

        // Power-up sequence seen by the device
        while (init_count < 4) @(negedge clk);
        if (model_errors != 0) begin
            $display("ERROR at %0t: init sequence differs from PRE, REF, REF, LMR", $time);
        end
        $display("test init: %s", (model_errors == 0) ? "ok" : "FAIL");
        note_result(model_errors == 0);

        for (int i = 0; i < test_addr.size(); i++) run_access(i);
        check_refresh_rate();

        @(posedge clk);
        if (acc_total != requests) begin
            $display("ERROR at %0t: %0d accepts for %0d requests", $time, acc_total,
                     requests);
            fail_count = fail_count + 1;
        end
        if (done_total != requests) begin
            $display("ERROR at %0t: %0d done pulses for %0d requests", $time, done_total,
                     requests);
            fail_count = fail_count + 1;
        end
        $display("tests passed %0d, failed %0d, device errors %0d", pass_count, fail_count,
                 model_errors);
        if (fail_count == 0 && model_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = test_addr.size() * 40 + sdram_pkg::T_RST_DLY + 4 * sdram_pkg::T_REF_INTERVAL;
        repeat (limit) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/sdram_tests.txt
# op addr data, addr is 24-bit hex laid out row[23:11] bank[10:9] col[8:0]
# W writes data to addr, R reads addr and expects data
W 009205 a5a5
W 009a05 5a5a
W 009405 1234
W 0093a0 c3c3
R 009205 a5a5
R 009a05 5a5a
R 009405 1234
R 0093a0 c3c3
W ffffff 0f0f
W 009205 beef
R ffffff 0f0f
R 009205 beef
R 009a05 5a5a

// File: sim.f
hw/sdram_pkg.sv
hw/sdram_seq.sv
hw/refresh_sched.sv
hw/cmd_encode.sv
hw/read_capture.sv
hw/sdram_ctrl.sv
verification/sdram_model.sv
verification/tb_sdram_ctrl.sv
